// ==== source/axi4_read_pkg.sv ====
/*
 * shared types and fixed AXI4 read settings for the read core,
 * imported by every module of the core
 */
package axi4_read_pkg;

    // ------------------------------
    // fixed bus settings
    // ------------------------------

    // 4-byte beats, INCR bursts, ID 0 on every request
    localparam int BEAT_BYTES = 4;

    // bursts never cross a 2**ALIGN_BITS byte boundary
    localparam int ALIGN_BITS = 12;

    // ------------------------------
    // types
    // ------------------------------

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0]  len_t;
    typedef logic [11:0] size_t;

    // size and max_len are both counts minus one
    typedef struct packed {
        addr_t address;
        size_t size;
        len_t  max_len;
    } rd_cmd_t;

    typedef struct packed {
        addr_t address;
        len_t  len;
    } ar_cmd_t;

    typedef enum logic [1:0] {
        IDLE,
        SPLIT,
        WAIT_CREDIT,
        ISSUE
    } ctrl_state_t;

endpackage

// ==== source/burst_splitter.sv ====
/*
 * combinational burst sizing: picks the next burst length from the remaining
 * beats, the command's max length and the distance to the 4 KiB boundary
 */
`timescale 1ns/1ps

module burst_splitter
    import axi4_read_pkg::*;
(
    input  addr_t   cur_addr,
    input  size_t   cur_remaining,
    input  len_t    cur_max_len,

    output ar_cmd_t burst,
    output addr_t   next_addr,
    output size_t   next_remaining,
    output logic    final_burst
);

    localparam int BEAT_SHIFT = $clog2(BEAT_BYTES);
    localparam int BOUND_W    = ALIGN_BITS - BEAT_SHIFT;

    // all lengths below are beat counts minus one
    logic [BOUND_W-1:0] bound_len;
    size_t              step_len;
    addr_t              step_bytes;

    // beats left before the boundary, minus one
    assign bound_len = ~cur_addr[ALIGN_BITS-1:BEAT_SHIFT];

    always_comb begin
        step_len = cur_remaining;
        if (size_t'(cur_max_len) < step_len) begin
            step_len = size_t'(cur_max_len);
        end
        if (size_t'(bound_len) < step_len) begin
            step_len = size_t'(bound_len);
        end
    end

    assign step_bytes = (addr_t'(step_len) + addr_t'(1)) << BEAT_SHIFT;

    assign burst.address  = cur_addr;
    assign burst.len      = len_t'(step_len);
    assign next_addr      = cur_addr + step_bytes;

    // wraps on the final burst, where it is not used
    assign next_remaining = cur_remaining - step_len - size_t'(1);
    assign final_burst    = (step_len == cur_remaining);

endmodule

// ==== source/fifo_credit.sv ====
/*
 * free slot counter of the read data FIFO: a burst reserves its beats
 * when issued and each stream pop returns one slot
 */
`timescale 1ns/1ps

module fifo_credit
    import axi4_read_pkg::*;
#(
    parameter int FIFO_PTR_WIDTH = 5
) (
    input  logic aclk,
    input  logic reset,
    input  len_t req_len,
    input  logic issue,
    input  logic pop,
    output logic credit_ok
);

    localparam int CNT_W = FIFO_PTR_WIDTH + 1;
    localparam int LEN_W = $bits(len_t) + 1;

    // compare wide enough for both a full count and a 256-beat request
    localparam int CMP_W = (CNT_W > LEN_W) ? CNT_W : LEN_W;

    localparam logic [CNT_W-1:0] DEPTH = CNT_W'(2 ** FIFO_PTR_WIDTH);

    logic [CNT_W-1:0] free_slots;
    logic [CNT_W-1:0] take;
    logic [CMP_W-1:0] need;

    assign need      = CMP_W'(req_len) + CMP_W'(1);
    assign credit_ok = (CMP_W'(free_slots) >= need);

    // only issued after credit_ok, so the reservation always fits
    assign take = issue ? (CNT_W'(req_len) + CNT_W'(1)) : '0;

    always_ff @(posedge aclk) begin
        if (reset) begin
            free_slots <= DEPTH;
        end else begin
            free_slots <= free_slots - take + CNT_W'(pop);
        end
    end

endmodule

// ==== source/read_data_fifo.sv ====
/*
 * synchronous FIFO from the R channel to the output stream,
 * circular buffer followed by a registered output stage
 */
`timescale 1ns/1ps

module read_data_fifo
    import axi4_read_pkg::*;
#(
    parameter int FIFO_PTR_WIDTH = 5
) (
    input  logic  aclk,
    input  logic  reset,

    input  data_t wr_data,
    input  logic  wr_valid,

    output data_t rd_data,
    output logic  rd_valid,
    input  logic  rd_ready
);

    localparam int DEPTH = 2 ** FIFO_PTR_WIDTH;

    data_t mem [DEPTH];

    // extra msb tells full from empty
    logic [FIFO_PTR_WIDTH:0] wr_ptr;
    logic [FIFO_PTR_WIDTH:0] rd_ptr;
    logic                    empty;
    logic                    load;

    assign empty = (wr_ptr == rd_ptr);

    // refill output stage when it is free or being drained
    assign load = !empty && (!rd_valid || rd_ready);

    // ------------------------------
    // storage
    // ------------------------------

    // no full check, credit keeps the writer below depth
    always_ff @(posedge aclk) begin
        if (wr_valid) begin
            mem[wr_ptr[FIFO_PTR_WIDTH-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr   <= rd_ptr + 1'b1;
                rd_valid <= 1'b1;
            end else if (rd_ready) begin
                rd_valid <= 1'b0;
            end
        end
    end

    // ------------------------------
    // output stage
    // ------------------------------

    always_ff @(posedge aclk) begin
        if (load) begin
            rd_data <= mem[rd_ptr[FIFO_PTR_WIDTH-1:0]];
        end
    end

endmodule

// ==== source/read_ctrl.sv ====
/*
 * command and burst sequencer: accepts a command, steps through its bursts,
 * holds each one until FIFO credit is available, then drives the AR channel
 */
`timescale 1ns/1ps

module read_ctrl
    import axi4_read_pkg::*;
(
    input  logic        aclk,
    input  logic        reset,

    input  rd_cmd_t     s_arcmd,
    input  logic        s_arvalid,
    output logic        s_arready,

    output addr_t       cur_addr,
    output size_t       cur_remaining,
    output len_t        cur_max_len,
    input  ar_cmd_t     burst,
    input  addr_t       next_addr,
    input  size_t       next_remaining,
    input  logic        final_burst,

    output len_t        req_len,
    output logic        issue,
    input  logic        credit_ok,

    output ar_cmd_t     m_axi4_ar,
    output logic        m_axi4_arvalid,
    input  logic        m_axi4_arready
);

    ctrl_state_t state;
    logic        last_burst;

    // ------------------------------
    // state machine
    // ------------------------------

    always_ff @(posedge aclk) begin
        if (reset) begin
            state      <= IDLE;
            last_burst <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (s_arvalid) begin
                        state <= SPLIT;
                    end
                end
                SPLIT: begin
                    last_burst <= final_burst;
                    state      <= WAIT_CREDIT;
                end
                WAIT_CREDIT: begin
                    // pops only add credit, so it stays ok from here
                    if (credit_ok) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (m_axi4_arready) begin
                        state <= last_burst ? IDLE : SPLIT;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // command and burst registers
    // ------------------------------

    always_ff @(posedge aclk) begin
        if (state == IDLE && s_arvalid) begin
            cur_addr      <= s_arcmd.address;
            cur_remaining <= s_arcmd.size;
            cur_max_len   <= s_arcmd.max_len;
        end
        // splitter result is captured, cursor moves on to the next burst
        if (state == SPLIT) begin
            m_axi4_ar     <= burst;
            cur_addr      <= next_addr;
            cur_remaining <= next_remaining;
        end
    end

    assign s_arready      = (state == IDLE);
    assign m_axi4_arvalid = (state == ISSUE);
    assign issue          = (state == ISSUE) && m_axi4_arready;
    assign req_len        = m_axi4_ar.len;

endmodule

// ==== source/axi4_read_core.sv ====
/*
 * AXI4 read engine top level: splits one command at a time into INCR bursts
 * and returns the beats in order on a valid/ready stream
 */
`timescale 1ns/1ps

module axi4_read_core
    import axi4_read_pkg::*;
#(
    parameter int FIFO_PTR_WIDTH = 5
) (
    input  logic    aclk,
    input  logic    reset,

    input  rd_cmd_t s_arcmd,
    input  logic    s_arvalid,
    output logic    s_arready,

    output ar_cmd_t m_axi4_ar,
    output logic    m_axi4_arvalid,
    input  logic    m_axi4_arready,
    input  data_t   m_axi4_rdata,
    input  logic    m_axi4_rlast,
    input  logic    m_axi4_rvalid,

    output data_t   s_rdata,
    output logic    s_rvalid,
    input  logic    s_rready
);

    addr_t   cur_addr;
    size_t   cur_remaining;
    len_t    cur_max_len;
    ar_cmd_t burst;
    addr_t   next_addr;
    size_t   next_remaining;
    logic    final_burst;
    len_t    req_len;
    logic    issue;
    logic    credit_ok;
    logic    pop;

    // rlast is not needed, credit already covers every beat of a burst
    assign pop = s_rvalid & s_rready;

    read_ctrl u_read_ctrl (
        .aclk           (aclk),
        .reset          (reset),
        .s_arcmd        (s_arcmd),
        .s_arvalid      (s_arvalid),
        .s_arready      (s_arready),
        .cur_addr       (cur_addr),
        .cur_remaining  (cur_remaining),
        .cur_max_len    (cur_max_len),
        .burst          (burst),
        .next_addr      (next_addr),
        .next_remaining (next_remaining),
        .final_burst    (final_burst),
        .req_len        (req_len),
        .issue          (issue),
        .credit_ok      (credit_ok),
        .m_axi4_ar      (m_axi4_ar),
        .m_axi4_arvalid (m_axi4_arvalid),
        .m_axi4_arready (m_axi4_arready)
    );

    burst_splitter u_burst_splitter (
        .cur_addr       (cur_addr),
        .cur_remaining  (cur_remaining),
        .cur_max_len    (cur_max_len),
        .burst          (burst),
        .next_addr      (next_addr),
        .next_remaining (next_remaining),
        .final_burst    (final_burst)
    );

    fifo_credit #(
        .FIFO_PTR_WIDTH (FIFO_PTR_WIDTH)
    ) u_fifo_credit (
        .aclk           (aclk),
        .reset          (reset),
        .req_len        (req_len),
        .issue          (issue),
        .pop            (pop),
        .credit_ok      (credit_ok)
    );

    read_data_fifo #(
        .FIFO_PTR_WIDTH (FIFO_PTR_WIDTH)
    ) u_read_data_fifo (
        .aclk           (aclk),
        .reset          (reset),
        .wr_data        (m_axi4_rdata),
        .wr_valid       (m_axi4_rvalid),
        .rd_data        (s_rdata),
        .rd_valid       (s_rvalid),
        .rd_ready       (s_rready)
    );

endmodule

// ==== verification/axi4_slave_model.sv ====
/*
 * AXI4 read slave for the testbench: each word is a fixed function of its address,
 * with random arready delays and random gaps between R beats
 */
`timescale 1ns/1ps

module axi4_slave_model
    import axi4_read_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h8fad_84f2
) (
    input  logic    aclk,
    input  logic    reset,
    input  ar_cmd_t ar,
    input  logic    arvalid,
    output logic    arready,
    output data_t   rdata,
    output logic    rlast,
    output logic    rvalid
);

    ar_cmd_t     pending[$];
    ar_cmd_t     cur;
    int unsigned beat;
    integer      seed;

    initial begin
        seed    = SEED;
        beat    = 0;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
    end

    // outputs change on the falling edge, the core samples them on the rising one
    always @(negedge aclk) begin
        if (reset) begin
            arready = 1'b0;
            rvalid  = 1'b0;
            rlast   = 1'b0;
            beat    = 0;
            pending.delete();
        end else begin
            // R first, so a burst accepted now is answered from the next cycle on
            rvalid = 1'b0;
            rlast  = 1'b0;
            if (pending.size() > 0 && ($random(seed) & 3) != 0) begin
                cur    = pending[0];
                rdata  = (cur.address + beat * BEAT_BYTES) ^ 32'h5a5a_0000;
                rlast  = (beat == cur.len);
                rvalid = 1'b1;
                if (beat == cur.len) begin
                    void'(pending.pop_front());
                    beat = 0;
                end else begin
                    beat = beat + 1;
                end
            end
            arready = arvalid && (($random(seed) % 3) != 0);
            if (arready) begin
                pending.push_back(ar);
            end
        end
    end

endmodule

// ==== verification/axi4_read_properties.sv ====
/*
 * concurrent checks on the AR side of the control FSM, bound to read_ctrl
 */
`timescale 1ns/1ps

module axi4_read_properties
    import axi4_read_pkg::*;
(
    input logic    aclk,
    input logic    reset,
    input logic    s_arready,
    input ar_cmd_t m_axi4_ar,
    input logic    m_axi4_arvalid,
    input logic    m_axi4_arready
);

    // request holds until it is accepted
    ar_stable: assert property (@(posedge aclk) disable iff (reset)
        (m_axi4_arvalid && !m_axi4_arready) |=> (m_axi4_arvalid && $stable(m_axi4_ar)))
        else $error("AR request changed or dropped before arready");

    reset_idle: assert property (@(posedge aclk)
        reset |=> (!m_axi4_arvalid && s_arready))
        else $error("control FSM not idle after reset");

endmodule

bind read_ctrl axi4_read_properties u_properties (
    .aclk           (aclk),
    .reset          (reset),
    .s_arready      (s_arready),
    .m_axi4_ar      (m_axi4_ar),
    .m_axi4_arvalid (m_axi4_arvalid),
    .m_axi4_arready (m_axi4_arready)
);

// ==== verification/tb_axi4_read.sv ====
/*
 * testbench for the AXI4 read core: random commands against the slave model,
 * burst, credit and data checks, then a run with the stream held off
 */
`timescale 1ns/1ps

module tb_axi4_read
    import axi4_read_pkg::*;
();

    localparam int    FIFO_PTR_WIDTH = 5;
    localparam int    FIFO_DEPTH     = 2 ** FIFO_PTR_WIDTH;
    localparam int    NUM_COMMANDS   = 40;
    localparam int    HOLD_CYCLES    = 100;
    localparam int    TIMEOUT_CYCLES = 5000;
    localparam data_t WORD_PATTERN   = 32'h5a5a_0000;

    logic    aclk;
    logic    reset;
    rd_cmd_t s_arcmd;
    logic    s_arvalid;
    logic    s_arready;
    ar_cmd_t m_axi4_ar;
    logic    m_axi4_arvalid;
    logic    m_axi4_arready;
    data_t   m_axi4_rdata;
    logic    m_axi4_rlast;
    logic    m_axi4_rvalid;
    data_t   s_rdata;
    logic    s_rvalid;
    logic    s_rready;

    // reference model state
    data_t   expected_words[$];
    rd_cmd_t ar_cmds[$];
    addr_t   ar_next_addr;
    int      ar_left;
    len_t    ar_max_len;
    int      issued_beats;
    int      popped_beats;
    logic    hold_ready;
    integer  seed;

    axi4_read_core #(
        .FIFO_PTR_WIDTH (FIFO_PTR_WIDTH)
    ) DUT (
        .aclk           (aclk),
        .reset          (reset),
        .s_arcmd        (s_arcmd),
        .s_arvalid      (s_arvalid),
        .s_arready      (s_arready),
        .m_axi4_ar      (m_axi4_ar),
        .m_axi4_arvalid (m_axi4_arvalid),
        .m_axi4_arready (m_axi4_arready),
        .m_axi4_rdata   (m_axi4_rdata),
        .m_axi4_rlast   (m_axi4_rlast),
        .m_axi4_rvalid  (m_axi4_rvalid),
        .s_rdata        (s_rdata),
        .s_rvalid       (s_rvalid),
        .s_rready       (s_rready)
    );

    axi4_slave_model u_slave (
        .aclk    (aclk),
        .reset   (reset),
        .ar      (m_axi4_ar),
        .arvalid (m_axi4_arvalid),
        .arready (m_axi4_arready),
        .rdata   (m_axi4_rdata),
        .rlast   (m_axi4_rlast),
        .rvalid  (m_axi4_rvalid)
    );

    always #10 aclk = ~aclk;

    // ------------------------------
    // checking helpers
    // ------------------------------

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    // expected length is the least of remaining beats, max_len + 1 and room in the page
    task automatic check_burst(input ar_cmd_t ar);
        rd_cmd_t cmd;
        addr_t   last_addr;
        int      exp_beats;
        int      to_boundary;
        if (ar_left == 0) begin
            if (ar_cmds.size() == 0) begin
                report_failure("AR burst issued while no command was pending");
            end
            cmd          = ar_cmds.pop_front();
            ar_next_addr = cmd.address;
            ar_left      = int'(cmd.size) + 1;
            ar_max_len   = cmd.max_len;
        end
        to_boundary = ((1 << ALIGN_BITS) - int'(ar_next_addr[ALIGN_BITS-1:0])) / BEAT_BYTES;
        exp_beats   = ar_left;
        if (int'(ar_max_len) + 1 < exp_beats) begin
            exp_beats = int'(ar_max_len) + 1;
        end
        if (to_boundary < exp_beats) begin
            exp_beats = to_boundary;
        end
        last_addr = ar.address + int'(ar.len) * BEAT_BYTES;
        check_value("burst address", ar_next_addr, ar.address);
        check_value("burst page", ar.address >> ALIGN_BITS, last_addr >> ALIGN_BITS);
        check_value("burst len", exp_beats - 1, ar.len);
        ar_next_addr = ar_next_addr + (int'(ar.len) + 1) * BEAT_BYTES;
        ar_left      = ar_left - (int'(ar.len) + 1);
    endtask

    // ------------------------------
    // stimulus tasks
    // ------------------------------

    task automatic send_command(input rd_cmd_t cmd);
        int cycles;
        for (int i = 0; i <= int'(cmd.size); i++) begin
            expected_words.push_back((cmd.address + i * BEAT_BYTES) ^ WORD_PATTERN);
        end
        ar_cmds.push_back(cmd);
        @(negedge aclk);
        s_arcmd   = cmd;
        s_arvalid = 1'b1;
        cycles    = 0;
        while (!s_arready) begin
            @(negedge aclk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_failure("timeout waiting for the core to accept a command");
            end
        end
        // accepted on the rising edge in between
        @(negedge aclk);
        s_arvalid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_words.size() != 0 || ar_cmds.size() != 0 || ar_left != 0
               || !s_arready) begin
            @(negedge aclk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_failure("timeout waiting for all read data to come back");
            end
        end
    endtask

    // ------------------------------
    // stream sink and AR monitor
    // ------------------------------

    always @(negedge aclk) begin
        if (!reset) begin
            s_rready = !hold_ready && (($random(seed) & 3) != 0);
            if (s_rvalid && s_rready) begin
                if (expected_words.size() == 0) begin
                    report_failure("stream returned a word that was never requested");
                end
                check_value("stream data", expected_words.pop_front(), s_rdata);
                popped_beats++;
            end
        end
    end

    // slave drives arready on the same edge, so look just after it
    always @(negedge aclk) begin
        #1;
        if (!reset && m_axi4_arvalid && m_axi4_arready) begin
            check_burst(m_axi4_ar);
            issued_beats = issued_beats + int'(m_axi4_ar.len) + 1;
        end
        check_value("FIFO credit limit", 1, (issued_beats - popped_beats) <= FIFO_DEPTH);
    end

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        rd_cmd_t     cmd;
        rd_cmd_t     commands[$];
        logic [31:0] r;
        addr_t       offset;
        data_t       held_data;
        logic        held_valid;

        seed         = 32'h8fad_84f2;
        aclk         = 1'b0;
        reset        = 1'b1;
        s_arcmd      = '0;
        s_arvalid    = 1'b0;
        s_rready     = 1'b0;
        hold_ready   = 1'b0;
        issued_beats = 0;
        popped_beats = 0;
        ar_left      = 0;

        // half the addresses sit in the last 64 words of a page
        for (int n = 0; n < NUM_COMMANDS; n++) begin
            r = $random(seed);
            cmd.address = r & 32'hffff_f000;
            r = $random(seed);
            if (r[0]) begin
                offset = 32'h0000_0ffc - (((r >> 1) & 32'h3f) << 2);
            end else begin
                offset = r & 32'h0000_0ffc;
            end
            cmd.address = cmd.address | offset;
            cmd.size    = size_t'($unsigned($random(seed)) % 200);
            cmd.max_len = len_t'($unsigned($random(seed)) % 32);
            commands.push_back(cmd);
        end

        repeat (2) @(posedge aclk);
        @(negedge aclk);
        reset <= 1'b0;
        check_value("reset arvalid", 0, m_axi4_arvalid);
        check_value("reset s_rvalid", 0, s_rvalid);
        check_value("reset s_arready", 1, s_arready);

        foreach (commands[n]) begin
            send_command(commands[n]);
        end
        wait_drain();

        // stream held off, bursts stop once the FIFO credit is used up
        hold_ready <= 1'b1;
        cmd.address = 32'h0000_0f80;
        cmd.size    = 12'd199;
        cmd.max_len = 8'd31;
        send_command(cmd);
        held_valid = 1'b0;
        held_data  = '0;
        for (int n = 0; n < HOLD_CYCLES; n++) begin
            @(negedge aclk);
            if (held_valid) begin
                check_value("held stream data", held_data, s_rdata);
            end else if (s_rvalid) begin
                held_valid = 1'b1;
                held_data  = s_rdata;
            end
        end
        check_value("stream valid while held", 1, s_rvalid);
        check_value("command stalled while held", 0, s_arready);
        hold_ready <= 1'b0;
        wait_drain();

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== tb.f ====
source/axi4_read_pkg.sv
source/burst_splitter.sv
source/fifo_credit.sv
source/read_data_fifo.sv
source/read_ctrl.sv
source/axi4_read_core.sv
verification/axi4_slave_model.sv
verification/axi4_read_properties.sv
verification/tb_axi4_read.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the AXI4 read core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axi4_read -f tb.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed"
    exit "$status"
fi

./obj_dir/Vtb_axi4_read
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit "$status"
fi

exit 0
